//--- source/robot_pkg.sv
// ---------------------------------------------------------------------
// Shared types, status register map and fixed constants of the robot
// car decision core. Design files refer to them by scoped name.
// ---------------------------------------------------------------------
package robot_pkg;

  // One colour channel
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t red;
    chan_t green;
    chan_t blue;
  } rgb_t;

  // One pixel beat from the camera path
  typedef struct packed {
    logic valid;
    logic line_end;
    logic frame_end;
    rgb_t rgb;
  } pix_t;

  // Centimetres, all ones when no echo came back
  typedef logic [15:0] distance_t;
  // One-hot steering, left in the MSB, zero for none
  typedef logic [2:0]  dir_t;
  typedef logic [9:0]  count_t;
  typedef logic [7:0]  ir_code_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] word_t;

  // Peer write request towards the status bank
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    word_t     data;
  } stat_wr_t;

  // Fields of one transfer on the internal APB bus
  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    word_t     data;
  } bus_xfer_t;

  typedef enum logic [1:0] {HALT, FORWARD, LEFT, RIGHT} motion_e;
  typedef enum logic [1:0] {IDLE, MANUAL, TRACK, BLOCKED} drive_state_e;

  // Status register map
  localparam reg_addr_t REG_DISTANCE = 4'd0;
  localparam reg_addr_t REG_TARGET   = 4'd1;
  localparam reg_addr_t REG_DRIVE    = 4'd2;
  localparam reg_addr_t REG_WRITES   = 4'd3;
  // Address bit set by the arbiter on host writes, the bank refuses them
  localparam reg_addr_t HOST_WR_FLAG = 4'h8;

  localparam dir_t DIR_NONE   = 3'b000;
  localparam dir_t DIR_LEFT   = 3'b100;
  localparam dir_t DIR_CENTRE = 3'b010;
  localparam dir_t DIR_RIGHT  = 3'b001;

  // Remote command codes
  localparam ir_code_t CMD_STOP    = 8'h16;
  localparam ir_code_t CMD_FORWARD = 8'h18;
  localparam ir_code_t CMD_TRACK   = 8'h1C;

  // Ultrasonic timing, 8 clocks of echo per centimetre
  localparam int        TRIG_CYCLES  = 10;
  localparam int        CM_SHIFT     = 3;
  localparam int        ECHO_TIMEOUT = 4096;
  localparam distance_t STOP_DIST    = 16'd20;
  localparam distance_t NO_ECHO      = '1;

  // Frame geometry, kept tiny
  localparam int LINE_WIDTH = 24;
  localparam int THIRD      = 8;
  localparam int DETECT_MIN = 4;
  localparam int COL_W      = $clog2(LINE_WIDTH);

  // Orange window
  localparam chan_t ORANGE_R_MIN = 8'd200;
  localparam chan_t ORANGE_G_MIN = 8'd60;
  localparam chan_t ORANGE_G_MAX = 8'd160;
  localparam chan_t ORANGE_B_MAX = 8'd80;
  localparam rgb_t  PURE_GREEN   = 24'h00FF00;

endpackage

//--- source/range_sensor.sv
// ---------------------------------------------------------------------
// Ultrasonic range sensor control. A measure pulse starts one reading;
// the result goes out on distance and as a REG_DISTANCE write.
// ---------------------------------------------------------------------
module range_sensor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 measure,
  input  logic                 echo,
  output logic                 trig,
  output robot_pkg::distance_t distance,
  output robot_pkg::stat_wr_t  req,
  input  logic                 ack
);

  typedef enum logic [1:0] {S_IDLE, S_TRIG, S_WAIT, S_COUNT} rs_state_e;

  rs_state_e            state_q;
  // One counter serves trigger width, echo wait and echo width
  logic [15:0]          cnt_q;
  logic                 done;
  robot_pkg::distance_t result;

  // Reading ends on the echo falling edge or on the wait timeout
  always_comb begin
    done   = 1'b0;
    result = robot_pkg::NO_ECHO;
    if (state_q == S_COUNT && !echo) begin
      done   = 1'b1;
      result = robot_pkg::distance_t'(cnt_q >> robot_pkg::CM_SHIFT);
    end else if (state_q == S_WAIT && !echo &&
                 cnt_q == 16'(robot_pkg::ECHO_TIMEOUT - 1)) begin
      done = 1'b1;
    end
  end

  assign trig = (state_q == S_TRIG);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= S_IDLE;
      cnt_q    <= '0;
      distance <= robot_pkg::NO_ECHO;
    end else begin
      case (state_q)
        // Measure pulses are only seen here
        S_IDLE: begin
          cnt_q <= '0;
          if (measure) state_q <= S_TRIG;
        end
        S_TRIG: begin
          cnt_q <= cnt_q + 16'd1;
          if (cnt_q == 16'(robot_pkg::TRIG_CYCLES - 1)) begin
            state_q <= S_WAIT;
            cnt_q   <= '0;
          end
        end
        S_WAIT: begin
          cnt_q <= cnt_q + 16'd1;
          if (echo) begin
            // First high cycle already counts
            state_q <= S_COUNT;
            cnt_q   <= 16'd1;
          end else if (done) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          if (!echo) state_q <= S_IDLE;
          else if (cnt_q != '1) cnt_q <= cnt_q + 16'd1;
        end
      endcase
      if (done) distance <= result;
    end
  end

  // Newest reading replaces one still waiting for its ack
  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else if (done) begin
      req.valid <= 1'b1;
      req.addr  <= robot_pkg::REG_DISTANCE;
      req.data  <= robot_pkg::word_t'(result);
    end else if (ack) begin
      req.valid <= 1'b0;
    end
  end

  // Trigger pulse lasts exactly TRIG_CYCLES
  trig_width_a: assert property (@(posedge clk) disable iff (rst)
    $rose(trig) |-> ##(robot_pkg::TRIG_CYCLES) !trig);

endmodule

//--- source/target_classifier.sv
// ---------------------------------------------------------------------
// Orange target finder on the pixel stream. Highlights orange pixels,
// counts them per third of the line and decides direction per frame.
// ---------------------------------------------------------------------
module target_classifier (
  input  logic                clk,
  input  logic                rst,
  input  robot_pkg::pix_t     pix_in,
  output robot_pkg::pix_t     pix_out,
  output robot_pkg::dir_t     dir,
  output logic                detected,
  output robot_pkg::stat_wr_t req,
  input  logic                ack
);

  typedef logic [robot_pkg::COL_W-1:0] col_t;

  logic              is_orange;
  logic              frame_done;
  col_t              col_q;
  // Third of the line, 0 left, 1 centre, 2 right
  logic [1:0]        third;
  robot_pkg::count_t cnt_q [3];
  robot_pkg::count_t cnt_d [3];
  robot_pkg::count_t total;
  robot_pkg::dir_t   dir_d;
  logic              det_d;

  assign is_orange = pix_in.valid &&
                     pix_in.rgb.red   >= robot_pkg::ORANGE_R_MIN &&
                     pix_in.rgb.green >= robot_pkg::ORANGE_G_MIN &&
                     pix_in.rgb.green <= robot_pkg::ORANGE_G_MAX &&
                     pix_in.rgb.blue  <= robot_pkg::ORANGE_B_MAX;
  assign frame_done = pix_in.valid && pix_in.frame_end;

  always_comb begin
    if (col_q < col_t'(robot_pkg::THIRD)) third = 2'd0;
    else if (col_q < col_t'(2 * robot_pkg::THIRD)) third = 2'd1;
    else third = 2'd2;
  end

  // Counts including the current beat, so frame_end pixel is not lost
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      cnt_d[i] = cnt_q[i];
      if (is_orange && third == 2'(i)) cnt_d[i] = cnt_q[i] + 10'd1;
    end
    total = cnt_d[0] + cnt_d[1] + cnt_d[2];
    // Ties favour centre, then left
    if (cnt_d[1] >= cnt_d[0] && cnt_d[1] >= cnt_d[2]) dir_d = robot_pkg::DIR_CENTRE;
    else if (cnt_d[0] >= cnt_d[2]) dir_d = robot_pkg::DIR_LEFT;
    else dir_d = robot_pkg::DIR_RIGHT;
    det_d = (total >= robot_pkg::count_t'(robot_pkg::DETECT_MIN));
    if (!det_d) dir_d = robot_pkg::DIR_NONE;
  end

  // Highlight path, one register stage, never stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_out.valid <= 1'b0;
    end else begin
      pix_out <= pix_in;
      if (is_orange) pix_out.rgb <= robot_pkg::PURE_GREEN;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col_q     <= '0;
      cnt_q     <= '{default: '0};
      dir       <= robot_pkg::DIR_NONE;
      detected  <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      if (pix_in.valid) begin
        col_q <= (pix_in.line_end || pix_in.frame_end) ? '0 : col_q + col_t'(1);
        // Counters restart with each frame
        if (frame_done) cnt_q <= '{default: '0};
        else cnt_q <= cnt_d;
      end
      if (frame_done) begin
        dir       <= dir_d;
        detected  <= det_d;
        req.valid <= 1'b1;
        req.addr  <= robot_pkg::REG_TARGET;
        req.data  <= {18'd0, det_d, dir_d, total};
      end else if (ack) begin
        req.valid <= 1'b0;
      end
    end
  end

  // Line length matches the frame geometry
  line_end_a: assert property (@(posedge clk) disable iff (rst)
    pix_in.valid |-> (pix_in.line_end == (col_q == col_t'(robot_pkg::LINE_WIDTH - 1))));

endmodule

//--- source/drive_fsm.sv
// ---------------------------------------------------------------------
// Drive mode FSM. Combines remote commands, target direction and the
// obstacle distance into a motion command; changes go to REG_DRIVE.
// ---------------------------------------------------------------------
module drive_fsm (
  input  logic                    clk,
  input  logic                    rst,
  input  robot_pkg::ir_code_t     ir_code,
  input  logic                    ir_valid,
  input  robot_pkg::dir_t         dir,
  input  logic                    detected,
  input  robot_pkg::distance_t    distance,
  output robot_pkg::motion_e      motion,
  output robot_pkg::stat_wr_t     req,
  input  logic                    ack
);

  // Mode chosen by the remote, kept while blocked so it can resume
  robot_pkg::drive_state_e mode_q;
  robot_pkg::drive_state_e mode_d;
  robot_pkg::drive_state_e state_q;
  robot_pkg::drive_state_e state_d;
  robot_pkg::motion_e      motion_d;

  always_comb begin
    mode_d = mode_q;
    if (ir_valid) begin
      case (ir_code)
        robot_pkg::CMD_STOP:    mode_d = robot_pkg::IDLE;
        robot_pkg::CMD_FORWARD: mode_d = robot_pkg::MANUAL;
        robot_pkg::CMD_TRACK:   mode_d = robot_pkg::TRACK;
        default:                mode_d = mode_q;
      endcase
    end
  end

  always_comb begin
    state_d = mode_d;
    // Obstacle too close overrides any moving mode
    if (mode_d != robot_pkg::IDLE && distance < robot_pkg::STOP_DIST) begin
      state_d = robot_pkg::BLOCKED;
    end
    case (state_d)
      robot_pkg::MANUAL: motion_d = robot_pkg::FORWARD;
      robot_pkg::TRACK: begin
        if (!detected) motion_d = robot_pkg::HALT;
        else if (dir == robot_pkg::DIR_LEFT) motion_d = robot_pkg::LEFT;
        else if (dir == robot_pkg::DIR_RIGHT) motion_d = robot_pkg::RIGHT;
        else if (dir == robot_pkg::DIR_CENTRE) motion_d = robot_pkg::FORWARD;
        else motion_d = robot_pkg::HALT;
      end
      default: motion_d = robot_pkg::HALT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mode_q    <= robot_pkg::IDLE;
      state_q   <= robot_pkg::IDLE;
      motion    <= robot_pkg::HALT;
      req.valid <= 1'b0;
    end else begin
      mode_q  <= mode_d;
      state_q <= state_d;
      motion  <= motion_d;
      // Report only on a change of state or motion
      if (state_d != state_q || motion_d != motion) begin
        req.valid <= 1'b1;
        req.addr  <= robot_pkg::REG_DRIVE;
        req.data  <= {28'd0, state_d, motion_d};
      end else if (ack) begin
        req.valid <= 1'b0;
      end
    end
  end

endmodule

//--- source/status_arbiter.sv
// ---------------------------------------------------------------------
// Round-robin owner of the internal APB bus. Serves the three peer
// write requests and the host APB port in grants of two cycles.
// ---------------------------------------------------------------------
module status_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  robot_pkg::stat_wr_t  range_req,
  input  robot_pkg::stat_wr_t  target_req,
  input  robot_pkg::stat_wr_t  drive_req,
  output logic                 range_ack,
  output logic                 target_ack,
  output logic                 drive_ack,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  robot_pkg::reg_addr_t paddr,
  input  robot_pkg::word_t     pwdata,
  output robot_pkg::word_t     prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 bus_psel,
  output logic                 bus_penable,
  output logic                 bus_pwrite,
  output robot_pkg::reg_addr_t bus_paddr,
  output robot_pkg::word_t     bus_pwdata,
  input  robot_pkg::word_t     bus_prdata,
  input  logic                 bus_pready,
  input  logic                 bus_pslverr
);

  // Host takes the last requester slot
  localparam logic [1:0] HOST = 2'd3;

  typedef enum logic {PH_SETUP, PH_ACCESS} phase_e;

  phase_e                phase_q;
  // Last granted slot and owner of the access cycle
  logic [1:0]            ptr_q;
  logic [1:0]            pick;
  logic [3:0]            reqs;
  logic                  setup_go;
  robot_pkg::bus_xfer_t  cand [4];
  robot_pkg::bus_xfer_t  xfer_q;
  robot_pkg::bus_xfer_t  xfer;

  // Host waits in its access cycle until served
  assign reqs = {psel && penable, drive_req.valid, target_req.valid, range_req.valid};

  always_comb begin
    cand[0] = {1'b1, range_req.addr, range_req.data};
    cand[1] = {1'b1, target_req.addr, target_req.data};
    cand[2] = {1'b1, drive_req.addr, drive_req.data};
    // Host writes are tagged so the bank answers with pslverr
    cand[3] = {pwrite, pwrite ? (paddr | robot_pkg::HOST_WR_FLAG) : paddr, pwdata};
  end

  // Nearest requester after the last grant wins
  always_comb begin
    logic [1:0] idx;
    pick = ptr_q;
    for (int i = 4; i >= 1; i--) begin
      idx = ptr_q + 2'(i);
      if (reqs[idx]) pick = idx;
    end
  end

  assign setup_go = (phase_q == PH_SETUP) && (|reqs);

  // Setup cycle drives the live candidate and access the latched copy
  assign xfer        = (phase_q == PH_ACCESS) ? xfer_q : cand[pick];
  assign bus_psel    = setup_go || (phase_q == PH_ACCESS);
  assign bus_penable = (phase_q == PH_ACCESS);
  assign bus_pwrite  = xfer.write;
  assign bus_paddr   = xfer.addr;
  assign bus_pwdata  = xfer.data;

  // Peers are released once their data is on the bus
  assign range_ack  = setup_go && pick == 2'd0;
  assign target_ack = setup_go && pick == 2'd1;
  assign drive_ack  = setup_go && pick == 2'd2;

  assign pready  = (phase_q == PH_ACCESS) && ptr_q == HOST && bus_pready;
  assign prdata  = bus_prdata;
  assign pslverr = pready && bus_pslverr;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_q <= PH_SETUP;
      ptr_q   <= HOST;
    end else if (setup_go) begin
      phase_q <= PH_ACCESS;
      ptr_q   <= pick;
    end else if (phase_q == PH_ACCESS && bus_pready) begin
      phase_q <= PH_SETUP;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_go) xfer_q <= cand[pick];
  end

  ack_onehot_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0({range_ack, target_ack, drive_ack}));

endmodule

//--- source/status_regs.sv
// ---------------------------------------------------------------------
// Status register bank, APB slave. Holds distance, target and drive
// words from the peers and counts accepted writes.
// ---------------------------------------------------------------------
module status_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 bus_psel,
  input  logic                 bus_penable,
  input  logic                 bus_pwrite,
  input  robot_pkg::reg_addr_t bus_paddr,
  input  robot_pkg::word_t     bus_pwdata,
  output robot_pkg::word_t     bus_prdata,
  output logic                 bus_pready,
  output logic                 bus_pslverr
);

  robot_pkg::word_t distance_q;
  robot_pkg::word_t target_q;
  robot_pkg::word_t drive_q;
  robot_pkg::word_t writes_q;
  logic             access;
  // Covers unmapped reads and the host write flag alike
  logic             bad_addr;

  assign access      = bus_psel && bus_penable;
  assign bad_addr    = bus_paddr > robot_pkg::REG_WRITES;
  assign bus_pready  = 1'b1;
  assign bus_pslverr = access && bad_addr;

  always_comb begin
    case (bus_paddr)
      robot_pkg::REG_DISTANCE: bus_prdata = distance_q;
      robot_pkg::REG_TARGET:   bus_prdata = target_q;
      robot_pkg::REG_DRIVE:    bus_prdata = drive_q;
      robot_pkg::REG_WRITES:   bus_prdata = writes_q;
      default:                 bus_prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      distance_q <= '0;
      target_q   <= '0;
      drive_q    <= '0;
      writes_q   <= '0;
    end else if (access && bus_pwrite && !bad_addr) begin
      case (bus_paddr)
        robot_pkg::REG_DISTANCE: distance_q <= bus_pwdata;
        robot_pkg::REG_TARGET:   target_q   <= bus_pwdata;
        robot_pkg::REG_DRIVE:    drive_q    <= bus_pwdata;
        default:                 ; // write counter is read only
      endcase
      writes_q <= writes_q + 32'd1;
    end
  end

endmodule

//--- source/robot_top.sv
// ---------------------------------------------------------------------
// Decision core of the robot car. Range sensor, target classifier and
// drive FSM report to a status bank shared with the host over APB.
// ---------------------------------------------------------------------
module robot_top (
  input  logic                 clk_50,
  input  logic                 rst,
  input  logic                 measure,
  input  logic                 echo,
  output logic                 trig,
  input  robot_pkg::pix_t      pix_in,
  output robot_pkg::pix_t      pix_out,
  input  robot_pkg::ir_code_t  ir_code,
  input  logic                 ir_valid,
  output robot_pkg::motion_e   motion,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  robot_pkg::reg_addr_t paddr,
  input  robot_pkg::word_t     pwdata,
  output robot_pkg::word_t     prdata,
  output logic                 pready,
  output logic                 pslverr
);

  robot_pkg::distance_t distance;
  robot_pkg::dir_t      dir;
  logic                 detected;

  // Peer requests and their acks
  robot_pkg::stat_wr_t range_req;
  robot_pkg::stat_wr_t target_req;
  robot_pkg::stat_wr_t drive_req;
  logic                range_ack;
  logic                target_ack;
  logic                drive_ack;

  // Internal APB bus to the register bank
  logic                 bus_psel;
  logic                 bus_penable;
  logic                 bus_pwrite;
  robot_pkg::reg_addr_t bus_paddr;
  robot_pkg::word_t     bus_pwdata;
  robot_pkg::word_t     bus_prdata;
  logic                 bus_pready;
  logic                 bus_pslverr;

  range_sensor u_range_sensor (
    .clk(clk_50), .rst(rst), .measure(measure), .echo(echo), .trig(trig),
    .distance(distance), .req(range_req), .ack(range_ack));

  target_classifier u_target_classifier (
    .clk(clk_50), .rst(rst), .pix_in(pix_in), .pix_out(pix_out), .dir(dir),
    .detected(detected), .req(target_req), .ack(target_ack));

  drive_fsm u_drive_fsm (
    .clk(clk_50), .rst(rst), .ir_code(ir_code), .ir_valid(ir_valid), .dir(dir),
    .detected(detected), .distance(distance), .motion(motion),
    .req(drive_req), .ack(drive_ack));

  status_arbiter u_status_arbiter (
    .clk(clk_50), .rst(rst),
    .range_req(range_req), .target_req(target_req), .drive_req(drive_req),
    .range_ack(range_ack), .target_ack(target_ack), .drive_ack(drive_ack),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .bus_psel(bus_psel), .bus_penable(bus_penable), .bus_pwrite(bus_pwrite),
    .bus_paddr(bus_paddr), .bus_pwdata(bus_pwdata), .bus_prdata(bus_prdata),
    .bus_pready(bus_pready), .bus_pslverr(bus_pslverr));

  status_regs u_status_regs (
    .clk(clk_50), .rst(rst),
    .bus_psel(bus_psel), .bus_penable(bus_penable), .bus_pwrite(bus_pwrite),
    .bus_paddr(bus_paddr), .bus_pwdata(bus_pwdata), .bus_prdata(bus_prdata),
    .bus_pready(bus_pready), .bus_pslverr(bus_pslverr));

endmodule

//--- bench/robot_tb.sv
// ----------------------------------------------------------------------
// Testbench for the robot car decision core. Runs a table of echo, frame,
// IR and host APB rows and checks the status bank, motion and pixels
// ----------------------------------------------------------------------
module robot_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int HOST_TIMEOUT = 50;
  localparam int TRIG_TIMEOUT = 50;
  // Long enough for a missing echo to run into the sensor timeout
  localparam int POLL_LIMIT   = 6000;
  localparam int ROW_CYCLES   = 8000;
  localparam int FRAME_LINES  = 2;

  localparam logic [2:0] OP_ECHO  = 3'd0;
  localparam logic [2:0] OP_FRAME = 3'd1;
  localparam logic [2:0] OP_IR    = 3'd2;
  localparam logic [2:0] OP_READ  = 3'd3;
  localparam logic [2:0] OP_WRITE = 3'd4;
  // Frame with a host read overlapping its result write
  localparam logic [2:0] OP_BUSY  = 3'd5;

  localparam robot_pkg::rgb_t ORANGE_RGB = 24'hE67828;
  localparam robot_pkg::rgb_t GREEN_RGB  = 24'h00FF00;

  // Frame args hold orange counts as left, centre, right bytes
  typedef struct packed {
    logic [2:0]           op;
    logic [31:0]          arg;
    robot_pkg::reg_addr_t addr;
    robot_pkg::word_t     exp;
  } row_t;

  logic                 clk;
  logic                 rst;
  logic                 measure;
  logic                 echo;
  logic                 trig;
  robot_pkg::pix_t      pix_in;
  robot_pkg::pix_t      pix_out;
  robot_pkg::ir_code_t  ir_code;
  logic                 ir_valid;
  robot_pkg::motion_e   motion;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  robot_pkg::reg_addr_t paddr;
  robot_pkg::word_t     pwdata;
  robot_pkg::word_t     prdata;
  logic                 pready;
  logic                 pslverr;

  row_t            rows[$];
  string           names[$];
  logic            table_ready = 1'b0;
  int              errors;
  int              checks;
  int              pix_errors = 0;
  int              pix_checks = 0;
  int              cycle = 0;
  integer          seed;
  logic            mon_on = 1'b0;
  robot_pkg::pix_t prev_pix = '0;

  robot_top robot_top_inst (
    .clk_50(clk), .rst(rst), .measure(measure), .echo(echo), .trig(trig),
    .pix_in(pix_in), .pix_out(pix_out), .ir_code(ir_code), .ir_valid(ir_valid),
    .motion(motion), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr));

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Orange window straight from the thresholds
  function automatic logic is_orange(input robot_pkg::rgb_t c);
    return c.red >= robot_pkg::ORANGE_R_MIN && c.green >= robot_pkg::ORANGE_G_MIN &&
           c.green <= robot_pkg::ORANGE_G_MAX && c.blue <= robot_pkg::ORANGE_B_MAX;
  endfunction

  function automatic robot_pkg::rgb_t random_plain();
    robot_pkg::rgb_t c;
    c = 24'($random(seed));
    // Rare orange draw pushed out of the window
    if (is_orange(c)) c.blue = 8'hFF;
    return c;
  endfunction

  function automatic void add_row(input string name, input logic [2:0] op,
                                  input logic [31:0] arg, input robot_pkg::reg_addr_t addr,
                                  input robot_pkg::word_t exp);
    rows.push_back(row_t'{op, arg, addr, exp});
    names.push_back(name);
  endfunction

  task automatic check_value(input string name, input robot_pkg::word_t exp,
                             input robot_pkg::word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // One host APB transfer with setup and then access until pready
  task automatic host_access(input logic wr, input robot_pkg::reg_addr_t addr,
                             input robot_pkg::word_t data, output robot_pkg::word_t rdata,
                             output logic err, output logic ok);
    int n;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!pready && n < HOST_TIMEOUT);
    ok    = pready;
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Peer writes land after arbitration, so reread until the value shows up
  task automatic read_until(input string name, input robot_pkg::reg_addr_t addr,
                            input robot_pkg::word_t exp);
    robot_pkg::word_t rdata;
    logic             err;
    logic             ok;
    int               start;
    start = cycle;
    do begin
      host_access(1'b0, addr, '0, rdata, err, ok);
    end while (ok && rdata !== exp && cycle - start < POLL_LIMIT);
    if (!ok) begin
      report_failure({name, ": host read got no pready"});
    end else begin
      check_value(name, exp, rdata);
      check_value({name, " pslverr"}, 32'd0, 32'(err));
    end
  endtask

  // Sensor model raising echo a few cycles after the trigger pulse
  task automatic run_echo(input string name, input int width);
    int n;
    int high;
    @(posedge clk);
    measure <= 1'b1;
    @(posedge clk);
    measure <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!trig && n < TRIG_TIMEOUT);
    // Trigger width in cycles, sampled away from the clock edges
    high = 0;
    while (trig && n < TRIG_TIMEOUT) begin
      high++;
      @(negedge clk);
      n++;
    end
    if (n >= TRIG_TIMEOUT) begin
      report_failure({name, ": trigger pulse never came or never ended"});
      return;
    end
    check_value({name, " trig width"}, 32'(robot_pkg::TRIG_CYCLES), 32'(high));
    repeat (3) @(posedge clk);
    // Zero width models an obstacle out of range
    if (width > 0) begin
      echo <= 1'b1;
      repeat (width) @(posedge clk);
      echo <= 1'b0;
    end
  endtask

  task automatic send_frame(input logic [23:0] counts);
    robot_pkg::pix_t p;
    int              third;
    int              offset;
    int              limit;
    for (int line = 0; line < FRAME_LINES; line++) begin
      for (int col = 0; col < robot_pkg::LINE_WIDTH; col++) begin
        third       = col / robot_pkg::THIRD;
        offset      = col % robot_pkg::THIRD;
        limit       = int'(counts[23 - 8 * third -: 8]);
        p.valid     = 1'b1;
        p.line_end  = (col == robot_pkg::LINE_WIDTH - 1);
        p.frame_end = p.line_end && (line == FRAME_LINES - 1);
        // Orange pixels fill each third from its left edge, line by line
        if (line * robot_pkg::THIRD + offset < limit) p.rgb = ORANGE_RGB;
        else p.rgb = random_plain();
        @(posedge clk);
        pix_in <= p;
      end
    end
    @(posedge clk);
    pix_in <= '0;
  endtask

  task automatic send_ir(input robot_pkg::ir_code_t code);
    @(posedge clk);
    ir_code  <= code;
    ir_valid <= 1'b1;
    @(posedge clk);
    ir_valid <= 1'b0;
  endtask

  task automatic run_row(input string name, input row_t r);
    robot_pkg::word_t rdata;
    logic             err;
    logic             ok;
    case (r.op)
      OP_ECHO:  run_echo(name, int'(r.arg));
      OP_FRAME: send_frame(r.arg[23:0]);
      OP_IR:    send_ir(r.arg[7:0]);
      OP_WRITE: begin
        host_access(1'b1, r.addr, r.arg, rdata, err, ok);
        if (!ok) report_failure({name, ": host write got no pready"});
        else check_value(name, r.exp, 32'(err));
      end
      OP_BUSY: begin
        fork
          send_frame(r.arg[23:0]);
          begin
            // Lands on the frame end against the target and drive writes
            repeat (FRAME_LINES * robot_pkg::LINE_WIDTH - 1) @(posedge clk);
            host_access(1'b0, r.addr, '0, rdata, err, ok);
          end
        join
        if (!ok) begin
          report_failure({name, ": host read got no pready"});
        end else begin
          check_value(name, r.exp, rdata);
          check_value({name, " pslverr"}, 32'd0, 32'(err));
        end
      end
      default: ;
    endcase
    if (r.op inside {OP_ECHO, OP_FRAME, OP_IR, OP_READ}) read_until(name, r.addr, r.exp);
    if (r.addr == robot_pkg::REG_DRIVE && r.op != OP_WRITE) begin
      check_value({name, " motion"}, 32'(r.exp[1:0]), 32'(motion));
    end
  endtask

  // REG_DRIVE is state in bits 3:2, motion in 1:0
  // REG_TARGET is detected in 13, direction in 12:10, total in 9:0
  task automatic build_table();
    add_row("reset writes", OP_READ, 0, robot_pkg::REG_WRITES, 32'd0);
    add_row("reset drive", OP_READ, 0, robot_pkg::REG_DRIVE, 32'h0);
    add_row("echo 203", OP_ECHO, 203, robot_pkg::REG_DISTANCE, 32'd25);
    add_row("echo missing", OP_ECHO, 0, robot_pkg::REG_DISTANCE, 32'h0000FFFF);
    add_row("frame centre", OP_FRAME, 32'h000502, robot_pkg::REG_TARGET, 32'h2807);
    add_row("frame tie left right", OP_FRAME, 32'h060006, robot_pkg::REG_TARGET, 32'h300C);
    add_row("frame tie all", OP_FRAME, 32'h030303, robot_pkg::REG_TARGET, 32'h2809);
    add_row("frame below min", OP_FRAME, 32'h010101, robot_pkg::REG_TARGET, 32'h0003);
    add_row("ir unknown idle", OP_IR, 32'h55, robot_pkg::REG_DRIVE, 32'h0);
    add_row("ir forward", OP_IR, 32'h18, robot_pkg::REG_DRIVE, 32'h5);
    add_row("ir track no target", OP_IR, 32'h1C, robot_pkg::REG_DRIVE, 32'h8);
    add_row("frame right", OP_FRAME, 32'h010209, robot_pkg::REG_TARGET, 32'h240C);
    add_row("track right", OP_READ, 0, robot_pkg::REG_DRIVE, 32'hB);
    add_row("frame left", OP_FRAME, 32'h0A0100, robot_pkg::REG_TARGET, 32'h300B);
    add_row("track left", OP_READ, 0, robot_pkg::REG_DRIVE, 32'hA);
    add_row("echo near", OP_ECHO, 100, robot_pkg::REG_DISTANCE, 32'd12);
    add_row("blocked", OP_READ, 0, robot_pkg::REG_DRIVE, 32'hC);
    add_row("ir unknown blocked", OP_IR, 32'h42, robot_pkg::REG_DRIVE, 32'hC);
    add_row("echo far", OP_ECHO, 400, robot_pkg::REG_DISTANCE, 32'd50);
    add_row("track resumed", OP_READ, 0, robot_pkg::REG_DRIVE, 32'hA);
    add_row("read during traffic", OP_BUSY, 32'h050500, robot_pkg::REG_DISTANCE, 32'd50);
    add_row("frame tie left centre", OP_READ, 0, robot_pkg::REG_TARGET, 32'h280A);
    add_row("track centre", OP_READ, 0, robot_pkg::REG_DRIVE, 32'h9);
    add_row("ir stop", OP_IR, 32'h16, robot_pkg::REG_DRIVE, 32'h0);
    add_row("host write rejected", OP_WRITE, 32'hDEAD, robot_pkg::REG_DISTANCE, 32'd1);
    add_row("distance kept", OP_READ, 0, robot_pkg::REG_DISTANCE, 32'd50);
    // 4 range, 7 target and 8 drive writes
    add_row("peer writes", OP_READ, 0, robot_pkg::REG_WRITES, 32'd19);
  endtask

  // Highlight output follows the input by one cycle
  always @(negedge clk) begin
    robot_pkg::pix_t want;
    if (mon_on) begin
      want = prev_pix;
      if (is_orange(prev_pix.rgb)) want.rgb = GREEN_RGB;
      if (prev_pix.valid) begin
        pix_checks++;
        if (pix_out !== want) begin
          pix_errors++;
          $display("** Error: pixel highlight expected %h actual %h", want, pix_out);
        end
      end else if (pix_out.valid !== 1'b0) begin
        pix_errors++;
        $display("Highlight output shows a valid pixel that was never sent");
      end
      prev_pix = pix_in;
    end
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * ROW_CYCLES) @(posedge clk);
    $display("Watchdog expired before the test table finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed     = 32'h595816eb;
    errors   = 0;
    checks   = 0;
    rst      = 1'b1;
    measure  = 1'b0;
    echo     = 1'b0;
    pix_in   = '0;
    ir_code  = '0;
    ir_valid = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    rst    <= 1'b0;
    mon_on = 1'b1;
    for (int i = 0; i < rows.size(); i++) run_row(names[i], rows[i]);
    $display("Checks: %0d, errors: %0d", checks + pix_checks, errors + pix_errors);
    if (errors + pix_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
source/robot_pkg.sv
source/range_sensor.sv
source/target_classifier.sv
source/drive_fsm.sv
source/status_arbiter.sv
source/status_regs.sv
source/robot_top.sv
bench/robot_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the robot core testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module robot_tb -f compile.f -o robot_sim

if ! ./obj_dir/robot_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulator exited with an error"
  exit 1
fi

cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0
